//--- src/fft_sched_config.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FFT scheduler configuration
// Transform size, memory latency and local-bus map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FFT_SCHED_CONFIG_SVH
`define FFT_SCHED_CONFIG_SVH

`define FFT_NUM_SAMPLES   128
`define FFT_IDX_W         7
`define FFT_NUM_STAGES    7
`define FFT_SAMPLE_W      32
`define FFT_TWDL_W        10

// Read latency of PCM, window, twiddle and cache memories
`define FFT_MEM_RD_DEL    2

`define FFT_LB_ADDR_W     12
`define FFT_LB_DATA_W     32
`define FFT_LB_REGION_W   4     // Region code in the top bits
`define FFT_LB_OFFS_W     8

`define FFT_REG_CONTROL   8'd0
`define FFT_REG_STATUS    8'd1
`define FFT_BAD_READ      32'hdeadbabe

`endif

//--- src/fft_sched_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FFT scheduler types
// Engine phase and local-bus region codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package fft_sched_pkg;

  // Engine phase
  typedef enum logic [1:0] {
    IDLE     = 2'd0,
    DECIMATE = 2'd1,   // Bit-reversed read and windowing
    FFT      = 2'd2,
    DONE     = 2'd3    // Single cycle, then back to IDLE
  } engine_state_e;

  // Top nibble of lb_addr
  typedef enum logic [3:0] {
    REGS  = 4'd0,
    CACHE = 4'd1,
    TWDL  = 4'd2,
    WIN   = 4'd3
  } lb_region_e;

endpackage

//--- src/fft_host_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FFT host port
// Control and status registers, bus readback and
// host or engine addressing of the coefficient RAMs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "fft_sched_config.svh"

module fft_host_port (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         lb_wr_en,
  input  logic                         lb_rd_en,
  input  logic [`FFT_LB_ADDR_W-1:0]    lb_addr,
  input  logic [`FFT_LB_DATA_W-1:0]    lb_wr_data,
  input  fft_sched_pkg::engine_state_e state,
  input  logic                         pcm_rdy,
  input  logic                         bffr_ovrflw,
  input  logic                         bffr_underflw,
  input  logic [`FFT_IDX_W-1:0]        eng_win_addr,
  input  logic [`FFT_IDX_W-1:0]        eng_twdl_addr,
  input  logic [`FFT_LB_DATA_W-1:0]    win_ram_rdata,
  input  logic [`FFT_LB_DATA_W-1:0]    twdl_ram_rdata,
  input  logic [`FFT_LB_DATA_W-1:0]    cache_hst_rdata,
  output logic                         lb_wr_valid,
  output logic                         lb_rd_valid,
  output logic [`FFT_LB_DATA_W-1:0]    lb_rd_data,
  output logic                         start,
  output logic [`FFT_IDX_W-1:0]        win_ram_addr,
  output logic                         win_ram_wren,
  output logic [`FFT_IDX_W-1:0]        twdl_ram_addr,
  output logic                         twdl_ram_wren,
  output logic                         cache_hst_wren,
  output logic [`FFT_IDX_W-1:0]        cache_hst_addr,
  output logic [`FFT_LB_DATA_W-1:0]    ram_wdata
);

  logic                         fft_en;
  logic                         cfg_mode;        // Host owns the RAM addresses
  logic                         ovrflw_seen;
  logic                         underflw_seen;
  logic                         busy;
  logic                         ctrl_sel;
  logic [`FFT_MEM_RD_DEL-1:0]   wr_pipe;
  logic [`FFT_MEM_RD_DEL-1:0]   rd_pipe;
  logic [`FFT_LB_ADDR_W-1:0]    addr_pipe [`FFT_MEM_RD_DEL];
  logic [`FFT_LB_ADDR_W-1:0]    rd_addr;
  fft_sched_pkg::lb_region_e    wr_region;
  fft_sched_pkg::lb_region_e    rd_region;

  assign wr_region = fft_sched_pkg::lb_region_e'(lb_addr[`FFT_LB_ADDR_W-1 -: `FFT_LB_REGION_W]);
  assign ctrl_sel  = (wr_region == fft_sched_pkg::REGS) &&
                     (lb_addr[`FFT_LB_OFFS_W-1:0] == `FFT_REG_CONTROL);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      fft_en        <= 1'b0;
      cfg_mode      <= 1'b0;
      ovrflw_seen   <= 1'b0;
      underflw_seen <= 1'b0;
      wr_pipe       <= '0;
      rd_pipe       <= '0;
    end
    else
    begin
      if (lb_wr_en && ctrl_sel)
      begin
        fft_en   <= lb_wr_data[0];
        cfg_mode <= lb_wr_data[1];
      end
      ovrflw_seen   <= ovrflw_seen | bffr_ovrflw;      // Sticky until reset
      underflw_seen <= underflw_seen | bffr_underflw;
      wr_pipe       <= {wr_pipe[`FFT_MEM_RD_DEL-2:0], lb_wr_en};
      rd_pipe       <= {rd_pipe[`FFT_MEM_RD_DEL-2:0], lb_rd_en};
    end
  end

  // Address follows the strobes so readback lines up with RAM data
  always_ff @(posedge clk)
  begin
    addr_pipe[0] <= lb_addr;
    for (int i = 1; i < `FFT_MEM_RD_DEL; i++)
    begin
      addr_pipe[i] <= addr_pipe[i-1];
    end
  end

  assign rd_addr     = addr_pipe[`FFT_MEM_RD_DEL-1];
  assign rd_region   = fft_sched_pkg::lb_region_e'(rd_addr[`FFT_LB_ADDR_W-1 -: `FFT_LB_REGION_W]);
  assign lb_wr_valid = wr_pipe[`FFT_MEM_RD_DEL-1];
  assign lb_rd_valid = rd_pipe[`FFT_MEM_RD_DEL-1];
  assign busy        = (state != fft_sched_pkg::IDLE);

  always_comb
  begin
    lb_rd_data = `FFT_BAD_READ;
    case (rd_region)
      fft_sched_pkg::REGS:
      begin
        case (rd_addr[`FFT_LB_OFFS_W-1:0])
          `FFT_REG_CONTROL: lb_rd_data = {{(`FFT_LB_DATA_W-2){1'b0}}, cfg_mode, fft_en};
          `FFT_REG_STATUS:  lb_rd_data = {{(`FFT_LB_DATA_W-3){1'b0}}, ovrflw_seen,
                                          underflw_seen, busy};
          default:          lb_rd_data = `FFT_BAD_READ;
        endcase
      end
      fft_sched_pkg::CACHE: lb_rd_data = cache_hst_rdata;
      fft_sched_pkg::TWDL:  lb_rd_data = twdl_ram_rdata;
      fft_sched_pkg::WIN:   lb_rd_data = win_ram_rdata;
      default:              lb_rd_data = `FFT_BAD_READ;
    endcase
  end

  // Level start, engine samples it while idle
  assign start = fft_en && pcm_rdy && !cfg_mode;

  assign win_ram_wren   = lb_wr_en && (wr_region == fft_sched_pkg::WIN);
  assign twdl_ram_wren  = lb_wr_en && (wr_region == fft_sched_pkg::TWDL);
  assign cache_hst_wren = lb_wr_en && (wr_region == fft_sched_pkg::CACHE);
  assign cache_hst_addr = lb_addr[`FFT_IDX_W-1:0];
  assign win_ram_addr   = cfg_mode ? lb_addr[`FFT_IDX_W-1:0] : eng_win_addr;
  assign twdl_ram_addr  = cfg_mode ? lb_addr[`FFT_IDX_W-1:0] : eng_twdl_addr;
  assign ram_wdata      = lb_wr_data;

  a_one_access: assert property (@(posedge clk) disable iff (!rst_n)
    !(lb_wr_en && lb_rd_en));

endmodule

//--- src/fft_addr_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FFT address generator
// Phase FSM, read and write counters, stage
// tracking and twiddle addressing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "fft_sched_config.svh"

module fft_addr_gen (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         start,
  input  logic                         res_rdy,
  output fft_sched_pkg::engine_state_e state,
  output logic                         pcm_rden,
  output logic [`FFT_IDX_W-1:0]        pcm_addr,
  output logic                         win_ram_rden,
  output logic [`FFT_IDX_W-1:0]        eng_win_addr,
  output logic                         twdl_ram_rden,
  output logic [`FFT_IDX_W-1:0]        eng_twdl_addr,
  output logic                         cache_rd_en,
  output logic [`FFT_IDX_W-1:0]        cache_raddr,
  output logic [`FFT_IDX_W-1:0]        cache_waddr,
  output logic                         wr_advance,
  output logic                         fft_done
);

  localparam logic [`FFT_IDX_W-1:0] LAST_IDX = `FFT_IDX_W'(`FFT_NUM_SAMPLES - 1);

  fft_sched_pkg::engine_state_e next_state;
  logic [`FFT_IDX_W-1:0]        rcnt;
  logic [`FFT_IDX_W-1:0]        wcnt;
  logic [`FFT_NUM_STAGES-1:0]   stg_rd;        // One-hot, bit s means span 2^s
  logic [`FFT_NUM_STAGES-1:0]   stg_wr;
  logic [`FFT_IDX_W-1:0]        rd_wrap;       // j mod span
  logic                         in_dec;
  logic                         in_fft;
  logic                         dec_wait;      // Idle slot between decimation reads
  logic                         rd_done;
  logic                         rd_issue;
  logic                         rd_stage_end;
  logic                         phase_end_q;   // Cycle of the phase's last cache write
  logic                         decimate_over;

  // Count k to butterfly address: pair k/2, upper element when k is odd
  function automatic logic [`FFT_IDX_W-1:0] pair_addr(input logic [`FFT_IDX_W-1:0] k,
                                                      input logic [`FFT_NUM_STAGES-1:0] stg);
    logic [`FFT_IDX_W-1:0] lo_mask;
    logic [`FFT_IDX_W-1:0] p;
    lo_mask = stg - 1'b1;
    p       = k >> 1;
    return ((p & ~lo_mask) << 1) | (p & lo_mask) | (stg & {`FFT_IDX_W{k[0]}});
  endfunction

  assign in_dec        = (state == fft_sched_pkg::DECIMATE);
  assign in_fft        = (state == fft_sched_pkg::FFT);
  assign rd_issue      = ((in_dec && !dec_wait) || in_fft) && !rd_done;
  assign rd_stage_end  = rd_issue && (rcnt == LAST_IDX);
  assign decimate_over = in_dec && phase_end_q;
  assign wr_advance    = res_rdy && (in_dec || in_fft);
  assign fft_done      = (state == fft_sched_pkg::DONE);

  assign pcm_rden      = in_dec && rd_issue;
  assign win_ram_rden  = pcm_rden;
  assign pcm_addr      = {<<{rcnt}};
  assign eng_win_addr  = {<<{rcnt}};
  assign cache_rd_en   = in_fft && rd_issue;
  assign cache_raddr   = pair_addr(rcnt, stg_rd);
  assign twdl_ram_rden = cache_rd_en && !rcnt[0];   // With the j read
  assign rd_wrap       = (rcnt >> 1) & (stg_rd - 1'b1);

  // Scale by 64/span, which is stage bit s mirrored
  always_comb
  begin
    eng_twdl_addr = '0;
    for (int i = 0; i < `FFT_NUM_STAGES; i++)
    begin
      if (stg_rd[i])
        eng_twdl_addr = rd_wrap << (`FFT_NUM_STAGES - 1 - i);
    end
  end

  always_comb
  begin
    next_state = state;
    case (state)
      fft_sched_pkg::IDLE:     if (start) next_state = fft_sched_pkg::DECIMATE;
      fft_sched_pkg::DECIMATE: if (decimate_over) next_state = fft_sched_pkg::FFT;
      fft_sched_pkg::FFT:      if (phase_end_q) next_state = fft_sched_pkg::DONE;
      default:                 next_state = fft_sched_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= fft_sched_pkg::IDLE;
    else
      state <= next_state;
  end

  // Read side
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rcnt     <= '0;
      stg_rd   <= `FFT_NUM_STAGES'(1);
      dec_wait <= 1'b0;
      rd_done  <= 1'b0;
    end
    else if (state == fft_sched_pkg::IDLE)
    begin
      rcnt     <= '0;
      stg_rd   <= `FFT_NUM_STAGES'(1);
      dec_wait <= 1'b0;
      rd_done  <= 1'b0;
    end
    else
    begin
      dec_wait <= in_dec && !dec_wait;
      if (rd_issue)
        rcnt <= rcnt + 1'b1;
      if (in_fft && rd_stage_end)
        stg_rd <= {stg_rd[`FFT_NUM_STAGES-2:0], stg_rd[`FFT_NUM_STAGES-1]};
      if (decimate_over)
        rd_done <= 1'b0;   // Reads restart for stage 0
      else if (rd_stage_end && (in_dec || stg_rd[`FFT_NUM_STAGES-1]))
        rd_done <= 1'b1;
    end
  end

  // Write side, steps once per accepted result
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wcnt        <= '0;
      stg_wr      <= `FFT_NUM_STAGES'(1);
      cache_waddr <= '0;
      phase_end_q <= 1'b0;
    end
    else
    begin
      phase_end_q <= wr_advance && (wcnt == LAST_IDX) &&
                     (in_dec || stg_wr[`FFT_NUM_STAGES-1]);
      if (state == fft_sched_pkg::IDLE)
      begin
        wcnt   <= '0;
        stg_wr <= `FFT_NUM_STAGES'(1);
      end
      else if (wr_advance)
      begin
        wcnt        <= wcnt + 1'b1;
        cache_waddr <= in_fft ? pair_addr(wcnt, stg_wr) : wcnt;   // In order when decimating
        if (in_fft && (wcnt == LAST_IDX))
          stg_wr <= {stg_wr[`FFT_NUM_STAGES-2:0], stg_wr[`FFT_NUM_STAGES-1]};
      end
    end
  end

  a_waddr_on_advance: assert property (@(posedge clk) disable iff (!rst_n)
    $changed(cache_waddr) |-> $past(wr_advance));

  a_no_done_to_fft: assert property (@(posedge clk) disable iff (!rst_n)
    (state == fft_sched_pkg::DONE) |=> (state != fft_sched_pkg::FFT));

endmodule

//--- src/fft_sample_feed.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FFT sample feed
// Butterfly operand loading and cache write-back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "fft_sched_config.svh"

module fft_sample_feed (
  input  logic                         clk,
  input  logic                         rst_n,
  input  fft_sched_pkg::engine_state_e state,
  input  logic [`FFT_SAMPLE_W-1:0]     pcm_rdata,
  input  logic                         pcm_rd_valid,
  input  logic [`FFT_LB_DATA_W-1:0]    win_ram_rdata,
  input  logic                         win_ram_rd_valid,
  input  logic [`FFT_LB_DATA_W-1:0]    twdl_ram_rdata,
  input  logic                         twdl_ram_rd_valid,
  input  logic [`FFT_SAMPLE_W-1:0]     cache_rd_re,
  input  logic [`FFT_SAMPLE_W-1:0]     cache_rd_im,
  input  logic                         cache_rd_valid,
  input  logic [`FFT_SAMPLE_W-1:0]     res_re,
  input  logic [`FFT_SAMPLE_W-1:0]     res_im,
  input  logic                         wr_advance,
  output logic [`FFT_SAMPLE_W-1:0]     sample_a_re,
  output logic [`FFT_SAMPLE_W-1:0]     sample_a_im,
  output logic [`FFT_SAMPLE_W-1:0]     sample_b_re,
  output logic [`FFT_SAMPLE_W-1:0]     sample_b_im,
  output logic [`FFT_TWDL_W-1:0]       twdl_re,
  output logic [`FFT_TWDL_W-1:0]       twdl_im,
  output logic                         sample_rdy,
  output logic                         cache_wr_en,
  output logic [`FFT_SAMPLE_W-1:0]     cache_wr_re,
  output logic [`FFT_SAMPLE_W-1:0]     cache_wr_im
);

  logic rd_odd;   // Next cache word is the j+span half

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sample_rdy  <= 1'b0;
      rd_odd      <= 1'b0;
      cache_wr_en <= 1'b0;
    end
    else
    begin
      cache_wr_en <= wr_advance;
      case (state)
        fft_sched_pkg::DECIMATE:
        begin
          sample_rdy <= pcm_rd_valid && win_ram_rd_valid;
          rd_odd     <= 1'b0;
        end
        fft_sched_pkg::FFT:
        begin
          sample_rdy <= cache_rd_valid && rd_odd;   // Both halves in
          if (cache_rd_valid)
            rd_odd <= !rd_odd;
        end
        default:
        begin
          sample_rdy <= 1'b0;
          rd_odd     <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    cache_wr_re <= res_re;
    cache_wr_im <= res_im;
    if (state == fft_sched_pkg::DECIMATE && pcm_rd_valid)
    begin
      sample_a_re <= '0;
      sample_a_im <= '0;
      sample_b_re <= pcm_rdata;
      sample_b_im <= '0;
      twdl_re     <= win_ram_rdata[`FFT_TWDL_W-1:0];   // Window coefficient
      twdl_im     <= '0;
    end
    if (state == fft_sched_pkg::FFT)
    begin
      if (cache_rd_valid)
      begin
        sample_a_re <= sample_b_re;
        sample_a_im <= sample_b_im;
        sample_b_re <= cache_rd_re;
        sample_b_im <= cache_rd_im;
      end
      if (twdl_ram_rd_valid)
      begin
        twdl_re <= twdl_ram_rdata[16 +: `FFT_TWDL_W];
        twdl_im <= twdl_ram_rdata[`FFT_TWDL_W-1:0];
      end
    end
  end

  a_no_rdy_idle: assert property (@(posedge clk) disable iff (!rst_n)
    sample_rdy |-> (state != fft_sched_pkg::IDLE));

endmodule

//--- src/fft_sched_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FFT scheduler top
// Host port, address generator and sample feed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "fft_sched_config.svh"

module fft_sched_top (
  input  logic                       clk,
  input  logic                       rst_n,
  // Local bus
  input  logic                       lb_wr_en,
  input  logic                       lb_rd_en,
  input  logic [`FFT_LB_ADDR_W-1:0]  lb_addr,
  input  logic [`FFT_LB_DATA_W-1:0]  lb_wr_data,
  output logic                       lb_wr_valid,
  output logic                       lb_rd_valid,
  output logic [`FFT_LB_DATA_W-1:0]  lb_rd_data,
  // PCM buffer
  input  logic                       pcm_rdy,
  output logic                       pcm_rden,
  output logic [`FFT_IDX_W-1:0]      pcm_addr,
  input  logic [`FFT_SAMPLE_W-1:0]   pcm_rdata,
  input  logic                       pcm_rd_valid,
  // Window and twiddle RAMs
  output logic [`FFT_IDX_W-1:0]      win_ram_addr,
  output logic                       win_ram_wren,
  output logic                       win_ram_rden,
  input  logic [`FFT_LB_DATA_W-1:0]  win_ram_rdata,
  input  logic                       win_ram_rd_valid,
  output logic [`FFT_IDX_W-1:0]      twdl_ram_addr,
  output logic                       twdl_ram_wren,
  output logic                       twdl_ram_rden,
  input  logic [`FFT_LB_DATA_W-1:0]  twdl_ram_rdata,
  input  logic                       twdl_ram_rd_valid,
  output logic [`FFT_LB_DATA_W-1:0]  ram_wdata,
  // Sample cache
  output logic                       cache_rd_en,
  output logic [`FFT_IDX_W-1:0]      cache_raddr,
  input  logic [`FFT_SAMPLE_W-1:0]   cache_rd_re,
  input  logic [`FFT_SAMPLE_W-1:0]   cache_rd_im,
  input  logic                       cache_rd_valid,
  output logic                       cache_wr_en,
  output logic [`FFT_IDX_W-1:0]      cache_waddr,
  output logic [`FFT_SAMPLE_W-1:0]   cache_wr_re,
  output logic [`FFT_SAMPLE_W-1:0]   cache_wr_im,
  output logic                       cache_hst_wren,
  output logic [`FFT_IDX_W-1:0]      cache_hst_addr,
  input  logic [`FFT_LB_DATA_W-1:0]  cache_hst_rdata,
  // Butterfly
  output logic [`FFT_SAMPLE_W-1:0]   sample_a_re,
  output logic [`FFT_SAMPLE_W-1:0]   sample_a_im,
  output logic [`FFT_SAMPLE_W-1:0]   sample_b_re,
  output logic [`FFT_SAMPLE_W-1:0]   sample_b_im,
  output logic [`FFT_TWDL_W-1:0]     twdl_re,
  output logic [`FFT_TWDL_W-1:0]     twdl_im,
  output logic                       sample_rdy,
  input  logic [`FFT_SAMPLE_W-1:0]   res_re,
  input  logic [`FFT_SAMPLE_W-1:0]   res_im,
  input  logic                       res_rdy,
  input  logic                       bffr_ovrflw,
  input  logic                       bffr_underflw,
  output logic                       fft_done
);

  fft_sched_pkg::engine_state_e state;
  logic                         start;
  logic [`FFT_IDX_W-1:0]        eng_win_addr;
  logic [`FFT_IDX_W-1:0]        eng_twdl_addr;
  logic                         wr_advance;   // Result accepted into the cache

  // Ports match the wire names one to one
  fft_host_port   u_host_port (.*);
  fft_addr_gen    u_addr_gen (.*);
  fft_sample_feed u_sample_feed (.*);

endmodule

//--- tests/fft_sched_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FFT scheduler testbench
// Memory and butterfly models, bus tests and
// full transforms checked against a reference FFT
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "fft_sched_config.svh"

module fft_sched_tb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum {OP_WR, OP_RD, OP_LOAD, OP_RUN, OP_OVF, OP_UNF} op_e;

  localparam int N          = `FFT_NUM_SAMPLES;
  localparam int NUM_TESTS  = 11;
  localparam int MAX_CYCLES = 3 * 1100 + N * 4 * 4 + NUM_TESTS * 16;

  logic clk = 1'b0;
  logic rst_n;
  logic lb_wr_en, lb_rd_en, lb_wr_valid, lb_rd_valid;
  logic [11:0] lb_addr;
  logic [31:0] lb_wr_data, lb_rd_data;
  logic pcm_rdy, pcm_rden, pcm_rd_valid;
  logic [6:0] pcm_addr, win_ram_addr, twdl_ram_addr, cache_raddr, cache_waddr, cache_hst_addr;
  logic [31:0] pcm_rdata, win_ram_rdata, twdl_ram_rdata, ram_wdata, cache_hst_rdata;
  logic win_ram_wren, win_ram_rden, win_ram_rd_valid;
  logic twdl_ram_wren, twdl_ram_rden, twdl_ram_rd_valid;
  logic cache_rd_en, cache_rd_valid, cache_wr_en, cache_hst_wren;
  logic [31:0] cache_rd_re, cache_rd_im, cache_wr_re, cache_wr_im;
  logic [31:0] sample_a_re, sample_a_im, sample_b_re, sample_b_im, res_re, res_im;
  logic [9:0] twdl_re, twdl_im;
  logic sample_rdy, res_rdy, bffr_ovrflw, bffr_underflw, fft_done;

  // Memory models and captured strobes
  logic [31:0] win_mem [N];
  logic [31:0] twdl_mem [N];
  logic [31:0] cache_re [N];
  logic [31:0] cache_im [N];
  logic [7:0]  pcm_p0, pcm_p1, win_p0, win_p1, twdl_p0, twdl_p1, crd_p0, crd_p1;
  logic [6:0]  hst_p0, hst_p1, cwaddr_n;
  logic [2:0]  wr_n;                    // win, twdl, host cache
  logic [31:0] wdata_n, cwre_n, cwim_n;
  logic        cwr_n;
  logic [63:0] res_q [$];
  int          due_q [$];

  // Expected values
  logic [31:0] win_val [N];
  logic [31:0] twdl_val [N];
  logic [31:0] ref_re [N];
  logic [31:0] ref_im [N];
  logic [31:0] dec_re [N];
  int          exp_raddr [$];
  int          exp_taddr [$];
  op_e         t_op [NUM_TESTS];
  logic [11:0] t_addr [NUM_TESTS];
  logic [31:0] t_data [NUM_TESTS];
  logic [31:0] t_exp [NUM_TESTS];

  integer seed = 32'h159ad77f;
  int cyc, errors, n_tests, failed_tests, err_before;
  int dec_cnt, wr_cnt, done_cnt, bf_cnt, act_cnt;
  logic cfg_watch;
  logic [31:0] rd_val;

  fft_sched_top uut (.*);

  always #20 clk = ~clk;

  function automatic logic [6:0] bitrev(input logic [6:0] v);
    logic [6:0] r;
    for (int i = 0; i < 7; i++)
      r[i] = v[6-i];
    return r;
  endfunction

  // Complex product b * tw with signed 10-bit twiddle parts
  function automatic logic [63:0] cmul(input logic [31:0] br, input logic [31:0] bi,
                                       input logic [9:0] tr, input logic [9:0] ti);
    logic signed [31:0] str;
    logic signed [31:0] sti;
    logic signed [31:0] r;
    logic signed [31:0] i;
    str = {{22{tr[9]}}, tr};
    sti = {{22{ti[9]}}, ti};
    r   = $signed(br) * str - $signed(bi) * sti;
    i   = $signed(br) * sti + $signed(bi) * str;
    return {r, i};
  endfunction

  task automatic note_failure(input string msg);
    errors++;
    $display("[ERROR] %0t %s", $time, msg);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic bus_write(input logic [11:0] a, input logic [31:0] d);
    @(posedge clk);
    lb_wr_en   <= 1'b1;
    lb_addr    <= a;
    lb_wr_data <= d;
    @(posedge clk);
    lb_wr_en <= 1'b0;
    @(negedge clk);
    if (lb_wr_valid)
      note_failure("lb_wr_valid came one cycle early");
    @(negedge clk);
    if (!lb_wr_valid)
      note_failure("lb_wr_valid missing two cycles after the write");
  endtask

  task automatic bus_read(input logic [11:0] a, output logic [31:0] d);
    @(posedge clk);
    lb_rd_en <= 1'b1;
    lb_addr  <= a;
    @(posedge clk);
    lb_rd_en <= 1'b0;
    @(negedge clk);
    if (lb_rd_valid)
      note_failure("lb_rd_valid came one cycle early");
    @(negedge clk);
    if (!lb_rd_valid)
      note_failure("lb_rd_valid missing two cycles after the read");
    d = lb_rd_data;
  endtask

  // Windowed decimation then 7 radix-2 stages along with the address order
  task automatic build_reference();
    logic [63:0] p;
    logic [31:0] ar;
    logic [31:0] ai;
    int span;
    int t;
    exp_raddr.delete();
    exp_taddr.delete();
    for (int k = 0; k < N; k++)
    begin
      p = cmul(bitrev(k) + 100, 32'd0, win_val[bitrev(k)][9:0], 10'd0);
      ref_re[k] = p[63:32];
      ref_im[k] = p[31:0];
      dec_re[k] = p[63:32];
    end
    for (int s = 0; s < `FFT_NUM_STAGES; s++)
    begin
      span = 1 << s;
      for (int j = 0; j < N; j++)
      begin
        if ((j & span) == 0)
        begin
          t = (j % span) * (64 / span);
          exp_raddr.push_back(j);
          exp_raddr.push_back(j + span);
          exp_taddr.push_back(t);
          p  = cmul(ref_re[j+span], ref_im[j+span], twdl_val[t][25:16], twdl_val[t][9:0]);
          ar = ref_re[j];
          ai = ref_im[j];
          ref_re[j]      = ar + p[63:32];
          ref_im[j]      = ai + p[31:0];
          ref_re[j+span] = ar - p[63:32];
          ref_im[j+span] = ai - p[31:0];
        end
      end
    end
  endtask

  task automatic load_coeffs();
    logic [31:0] d;
    cfg_watch = 1'b1;
    act_cnt   = 0;
    for (int i = 0; i < N; i++)
    begin
      win_val[i]  = $random(seed);
      twdl_val[i] = $random(seed);
      bus_write(12'h300 + i, win_val[i]);
      bus_write(12'h200 + i, twdl_val[i]);
    end
    for (int i = 0; i < N; i++)
    begin
      bus_read(12'h300 + i, d);
      check_val("win_ram_rdata", d, win_val[i]);
      bus_read(12'h200 + i, d);
      check_val("twdl_ram_rdata", d, twdl_val[i]);
    end
    cfg_watch = 1'b0;
    if (act_cnt != 0)
      note_failure("engine issued reads while config mode was set");
  endtask

  task automatic run_transform(input logic [31:0] exp_status);
    logic [31:0] d;
    build_reference();
    dec_cnt  = 0;
    wr_cnt   = 0;
    done_cnt = 0;
    bf_cnt   = 0;
    bus_write(12'h000, 32'd1);   // Enable in normal mode
    bus_write(12'h000, 32'd0);   // Engine keeps running once started
    bus_read(12'h001, d);
    check_val("status.busy", {31'd0, d[0]}, 32'd1);
    while (wr_cnt < N)
      @(negedge clk);
    for (int k = 0; k < N; k++)
      check_val("cache_re after decimation", cache_re[k], dec_re[k]);
    while (done_cnt == 0)
      @(negedge clk);
    repeat (4) @(negedge clk);
    check_val("fft_done pulses", done_cnt, 32'd1);
    check_val("pcm reads", dec_cnt, N);
    check_val("cache reads left", exp_raddr.size(), 32'd0);
    check_val("twiddle reads left", exp_taddr.size(), 32'd0);
    for (int k = 0; k < N; k++)
    begin
      check_val("cache_re", cache_re[k], ref_re[k]);
      check_val("cache_im", cache_im[k], ref_im[k]);
    end
    bus_read(12'h001, d);
    check_val("status", d, exp_status);
  endtask

  task automatic pulse_flag(input logic ovf, input logic [31:0] exp_status);
    logic [31:0] d;
    @(posedge clk);
    bffr_ovrflw   <= ovf;
    bffr_underflw <= !ovf;
    @(posedge clk);
    bffr_ovrflw   <= 1'b0;
    bffr_underflw <= 1'b0;
    repeat (3) @(posedge clk);
    bus_read(12'h001, d);
    check_val("status", d, exp_status);
  endtask

  task automatic add_test(input op_e op, input logic [11:0] a, input logic [31:0] d,
                          input logic [31:0] e);
    t_op[n_tests]   = op;
    t_addr[n_tests] = a;
    t_data[n_tests] = d;
    t_exp[n_tests]  = e;
    n_tests++;
  endtask

  // Strobes captured mid-cycle for the next rising edge
  always @(negedge clk)
  begin
    pcm_p0   <= {pcm_rden, pcm_addr};
    win_p0   <= {win_ram_rden, win_ram_addr};
    twdl_p0  <= {twdl_ram_rden, twdl_ram_addr};
    crd_p0   <= {cache_rd_en, cache_raddr};
    hst_p0   <= cache_hst_addr;
    wr_n     <= {win_ram_wren, twdl_ram_wren, cache_hst_wren};
    wdata_n  <= ram_wdata;
    cwr_n    <= cache_wr_en;
    cwaddr_n <= cache_waddr;
    cwre_n   <= cache_wr_re;
    cwim_n   <= cache_wr_im;
  end

  always @(posedge clk)
  begin
    pcm_p1            <= pcm_p0;
    win_p1            <= win_p0;
    twdl_p1           <= twdl_p0;
    crd_p1            <= crd_p0;
    hst_p1            <= hst_p0;
    pcm_rd_valid      <= pcm_p1[7];
    pcm_rdata         <= pcm_p1[6:0] + 32'd100;   // PCM word k is k plus 100
    win_ram_rd_valid  <= win_p1[7];
    win_ram_rdata     <= win_mem[win_p1[6:0]];
    twdl_ram_rd_valid <= twdl_p1[7];
    twdl_ram_rdata    <= twdl_mem[twdl_p1[6:0]];
    cache_rd_valid    <= crd_p1[7];
    cache_rd_re       <= cache_re[crd_p1[6:0]];
    cache_rd_im       <= cache_im[crd_p1[6:0]];
    cache_hst_rdata   <= cache_re[hst_p1];
    if (wr_n[2])
      win_mem[win_p0[6:0]] <= wdata_n;
    if (wr_n[1])
      twdl_mem[twdl_p0[6:0]] <= wdata_n;
    if (wr_n[0])
    begin
      cache_re[hst_p0] <= wdata_n;
      cache_im[hst_p0] <= '0;
    end
    if (cwr_n)
    begin
      cache_re[cwaddr_n] <= cwre_n;
      cache_im[cwaddr_n] <= cwim_n;
      wr_cnt <= wr_cnt + 1;
    end
    // Butterfly result port drains one result per cycle
    if (res_q.size() > 0 && due_q[0] <= cyc)
    begin
      res_rdy <= 1'b1;
      res_re  <= res_q[0][63:32];
      res_im  <= res_q[0][31:0];
      void'(res_q.pop_front());
      void'(due_q.pop_front());
    end
    else
      res_rdy <= 1'b0;
  end

  // Butterfly model and address monitors
  always @(negedge clk)
  begin
    logic [63:0] p;
    if (sample_rdy)
    begin
      p = cmul(sample_b_re, sample_b_im, twdl_re, twdl_im);
      if (bf_cnt < N)
        res_q.push_back(p);    // Decimation has a at zero
      else
      begin
        res_q.push_back({sample_a_re + p[63:32], sample_a_im + p[31:0]});
        res_q.push_back({sample_a_re - p[63:32], sample_a_im - p[31:0]});
        due_q.push_back(cyc + 4);
      end
      due_q.push_back(cyc + 4);
      bf_cnt++;
    end
    if (cfg_watch && (pcm_rden || win_ram_rden || twdl_ram_rden || cache_rd_en))
      act_cnt++;
    if (pcm_rden)
    begin
      check_val("pcm_addr", pcm_addr, bitrev(dec_cnt));
      check_val("win_ram_addr", win_ram_addr, bitrev(dec_cnt));
      dec_cnt++;
    end
    if (cache_rd_en)
    begin
      if (exp_raddr.size() == 0)
        note_failure("cache read beyond the last stage");
      else
        check_val("cache_raddr", cache_raddr, exp_raddr.pop_front());
    end
    if (twdl_ram_rden)
    begin
      if (exp_taddr.size() == 0)
        note_failure("twiddle read beyond the last stage");
      else
        check_val("twdl_ram_addr", twdl_ram_addr, exp_taddr.pop_front());
    end
    if (fft_done)
      done_cnt++;
  end

  always @(negedge clk)
  begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES)
    begin
      $display("[ERROR] %0t run did not finish within %0d cycles", $time, MAX_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial
  begin
    rst_n = 1'b0;
    lb_wr_en = 1'b0;
    lb_rd_en = 1'b0;
    lb_addr = '0;
    lb_wr_data = '0;
    pcm_rdy = 1'b1;
    bffr_ovrflw = 1'b0;
    bffr_underflw = 1'b0;
    res_rdy = 1'b0;
    res_re = '0;
    res_im = '0;
    pcm_rdata = '0;
    pcm_rd_valid = 1'b0;
    win_ram_rdata = '0;
    win_ram_rd_valid = 1'b0;
    twdl_ram_rdata = '0;
    twdl_ram_rd_valid = 1'b0;
    cache_rd_re = '0;
    cache_rd_im = '0;
    cache_rd_valid = 1'b0;
    cache_hst_rdata = '0;
    cyc = 0;
    errors = 0;
    n_tests = 0;
    failed_tests = 0;
    cfg_watch = 1'b0;
    add_test(OP_WR,   12'h000, 32'd3, 32'd0);          // Enable plus config mode
    add_test(OP_RD,   12'h000, 32'd0, 32'd3);
    add_test(OP_RD,   12'h0f0, 32'd0, `FFT_BAD_READ);
    add_test(OP_RD,   12'h700, 32'd0, `FFT_BAD_READ);
    add_test(OP_LOAD, 12'h000, 32'd0, 32'd0);
    add_test(OP_WR,   12'h105, 32'h1234abcd, 32'd0);
    add_test(OP_RD,   12'h105, 32'd0, 32'h1234abcd);
    add_test(OP_RUN,  12'h000, 32'd0, 32'd0);
    add_test(OP_OVF,  12'h001, 32'd0, 32'd4);
    add_test(OP_UNF,  12'h001, 32'd0, 32'd6);
    add_test(OP_RUN,  12'h000, 32'd0, 32'd6);          // Sticky flags survive
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    for (int i = 0; i < n_tests; i++)
    begin
      err_before = errors;
      case (t_op[i])
        OP_WR:   bus_write(t_addr[i], t_data[i]);
        OP_RD:
        begin
          bus_read(t_addr[i], rd_val);
          check_val("lb_rd_data", rd_val, t_exp[i]);
        end
        OP_LOAD: load_coeffs();
        OP_RUN:  run_transform(t_exp[i]);
        OP_OVF:  pulse_flag(1'b1, t_exp[i]);
        default: pulse_flag(1'b0, t_exp[i]);
      endcase
      if (errors != err_before)
        failed_tests++;
      $display("test %0d %s addr %h: %s", i, t_op[i].name(), t_addr[i],
               (errors == err_before) ? "ok" : "FAILED");
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d", n_tests,
             n_tests - failed_tests, failed_tests, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+src
src/fft_sched_pkg.sv
src/fft_host_port.sv
src/fft_addr_gen.sv
src/fft_sample_feed.sv
src/fft_sched_top.sv
tests/fft_sched_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = fft_sched_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out=$$(./$(SIM)); status=$$?; echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -q "^=== PASS ===$$"

clean:
	rm -rf $(OBJ_DIR)
